//--- verilog/rv_front_pkg.sv
package rv_front_pkg;

  // Address width of the front end
  parameter int XLEN = 32;

  typedef logic [XLEN-1:0] addr_t;

  // Next-PC source chosen by the arbiter
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL = 2'd0,
    PC_SEL_PREDICTED  = 2'd1,
    PC_SEL_REDIRECT   = 2'd2
  } pc_sel_e;

  // Execute redirect, also used for the decode late prediction
  typedef struct packed {
    logic  valid;
    addr_t tgt;
  } redirect_t;

  // Predictor training from execute
  typedef struct packed {
    logic  valid;
    addr_t pc;
    addr_t tgt;
    logic  is_return;
    logic  is_call;
  } bp_update_t;

  // BTB lookup result for the current PC
  typedef struct packed {
    logic  hit;
    logic  pred_taken;
    logic  is_return;
    addr_t tgt;
  } btb_meta_t;

  // RAS top entry
  typedef struct packed {
    logic  valid;
    addr_t tgt;
  } ras_meta_t;

  // Request bundle handed to IF
  typedef struct packed {
    addr_t     pc;
    addr_t     pc_next;
    btb_meta_t btb;
    ras_meta_t ras;
    logic      redir_pending;
  } fetch_req_t;

endpackage

//--- verilog/rv_pipe_ctrl.sv
`timescale 1ns/1ps

module rv_pipe_ctrl #(
  parameter int REG = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic stall_i,
  output logic valid_o,
  output logic advance_o
);

  // Source stage, so it moves whenever the hazard unit allows
  assign advance_o = !stall_i;

  if (REG != 0) begin : g_reg
    logic valid_q;

    // Valid drops on any stalled edge and comes back on the next free one
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= 1'b0;
      end else begin
        valid_q <= !stall_i;
      end
    end

    assign valid_o = valid_q;
  end else begin : g_pass
    // Combinational valid, same cycle as the request
    assign valid_o = !stall_i;
  end

endmodule

//--- verilog/rv_pipe_data.sv
`timescale 1ns/1ps

module rv_pipe_data #(
  parameter int WIDTH = 32,
  parameter int REG   = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             advance_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o
);

  if (REG != 0) begin : g_reg
    logic [WIDTH-1:0] data_q;

    // Holds while stalled, clears to zero on reset
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        data_q <= '0;
      end else if (advance_i) begin
        data_q <= data_i;
      end
    end

    assign data_o = data_q;
  end else begin : g_pass
    assign data_o = data_i;
  end

endmodule

//--- verilog/rv_btb.sv
`timescale 1ns/1ps

module rv_btb #(
  parameter int ENTRIES = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rv_front_pkg::addr_t      pc_i,
  input  rv_front_pkg::bp_update_t update_i,
  input  rv_front_pkg::ras_meta_t  ras_i,
  output rv_front_pkg::btb_meta_t  meta_o
);

  // Index from pc[IDX_W+1:2] and tag from the bits above it
  localparam int IDX_W = $clog2(ENTRIES);
  localparam int TAG_W = rv_front_pkg::XLEN - IDX_W - 2;

  logic                valid_q [ENTRIES];
  logic [TAG_W-1:0]    tag_q   [ENTRIES];
  rv_front_pkg::addr_t tgt_q   [ENTRIES];
  logic                ret_q   [ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  logic             rd_hit;

  assign rd_idx = pc_i[IDX_W+1:2];
  assign rd_tag = pc_i[rv_front_pkg::XLEN-1:IDX_W+2];
  assign wr_idx = update_i.pc[IDX_W+1:2];
  assign wr_tag = update_i.pc[rv_front_pkg::XLEN-1:IDX_W+2];

  // Valid bits clear on reset and set on every update
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (update_i.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Newest update replaces the entry payload on an index conflict
  always_ff @(posedge clk) begin
    if (update_i.valid) begin
      tag_q[wr_idx] <= wr_tag;
      tgt_q[wr_idx] <= update_i.tgt;
      ret_q[wr_idx] <= update_i.is_return;
    end
  end

  assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

  // Lookup for the current PC
  always_comb begin
    meta_o = '0;
    if (rd_hit) begin
      meta_o.hit       = 1'b1;
      meta_o.is_return = ret_q[rd_idx];
      if (ret_q[rd_idx]) begin
        // Returns follow the RAS and stay unpredicted while it is empty
        meta_o.pred_taken = ras_i.valid;
        meta_o.tgt        = ras_i.tgt;
      end else begin
        meta_o.pred_taken = 1'b1;
        meta_o.tgt        = tgt_q[rd_idx];
      end
    end
  end

endmodule

//--- verilog/rv_ras.sv
`timescale 1ns/1ps

module rv_ras #(
  parameter int DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_i,
  input  logic                   pop_i,
  input  rv_front_pkg::addr_t     push_addr_i,
  output rv_front_pkg::ras_meta_t top_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  rv_front_pkg::addr_t stack_q [DEPTH];
  logic [PTR_W-1:0]    top_q;
  logic [CNT_W-1:0]    cnt_q;
  logic [PTR_W-1:0]    ptr_inc;
  logic [PTR_W-1:0]    ptr_dec;
  logic                do_pop;
  logic                full;

  // Circular pointer arithmetic, DEPTH need not be a power of two
  assign ptr_inc = (top_q == PTR_W'(DEPTH - 1)) ? '0 : top_q + 1'b1;
  assign ptr_dec = (top_q == '0) ? PTR_W'(DEPTH - 1) : top_q - 1'b1;
  assign full    = (cnt_q == CNT_W'(DEPTH));
  // Pop on empty is dropped
  assign do_pop  = pop_i && (cnt_q != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      top_q <= '0;
      cnt_q <= '0;
    end else if (push_i && !do_pop) begin
      // Full push overwrites the oldest slot, count saturates
      top_q <= ptr_inc;
      if (!full) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (do_pop && !push_i) begin
      top_q <= ptr_dec;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Push with pop replaces the top in place
  always_ff @(posedge clk) begin
    if (push_i && do_pop) begin
      stack_q[top_q] <= push_addr_i;
    end else if (push_i) begin
      stack_q[ptr_inc] <= push_addr_i;
    end
  end

  assign top_o.valid = (cnt_q != '0);
  assign top_o.tgt   = top_o.valid ? stack_q[top_q] : '0;

endmodule

//--- verilog/rv_pc_sel.sv
`timescale 1ns/1ps

module rv_pc_sel (
  input  logic                   stall_i,
  input  rv_front_pkg::redirect_t redirect_i,
  input  rv_front_pkg::redirect_t late_pred_i,
  input  rv_front_pkg::btb_meta_t btb_i,
  output rv_front_pkg::pc_sel_e   pc_sel_o,
  output rv_front_pkg::addr_t     redir_tgt_o,
  output rv_front_pkg::addr_t     pred_tgt_o,
  output logic                   btb_early_o,
  output logic                   ras_pop_o
);

  // Redirect target only matters when the redirect wins
  assign redir_tgt_o = redirect_i.tgt;

  // Fixed priority: redirect, late prediction, BTB, then pc + 4
  always_comb begin
    pc_sel_o    = rv_front_pkg::PC_SEL_SEQUENTIAL;
    pred_tgt_o  = btb_i.tgt;
    btb_early_o = 1'b0;
    if (redirect_i.valid) begin
      pc_sel_o = rv_front_pkg::PC_SEL_REDIRECT;
    end else if (late_pred_i.valid) begin
      pc_sel_o   = rv_front_pkg::PC_SEL_PREDICTED;
      pred_tgt_o = late_pred_i.tgt;
    end else if (btb_i.pred_taken) begin
      // Early prediction, the sequential fetch never went out
      pc_sel_o    = rv_front_pkg::PC_SEL_PREDICTED;
      btb_early_o = 1'b1;
    end
  end

  // A taken BTB return already implies a valid RAS top
  // Pop only when that prediction is consumed by an advancing stage
  always_comb begin
    ras_pop_o = 1'b0;
    if (!stall_i && btb_early_o && btb_i.is_return) begin
      ras_pop_o = 1'b1;
    end
  end

endmodule

//--- verilog/rv_stage_pc.sv
`timescale 1ns/1ps

module rv_stage_pc #(
  parameter int                  PC_REG   = 1,
  parameter rv_front_pkg::addr_t RESET_PC = 32'h0000_1000
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall_i,
  input  rv_front_pkg::pc_sel_e    pc_sel_i,
  input  rv_front_pkg::addr_t      redir_tgt_i,
  input  rv_front_pkg::addr_t      pred_tgt_i,
  input  logic                    btb_early_i,
  input  rv_front_pkg::btb_meta_t  btb_i,
  input  rv_front_pkg::ras_meta_t  ras_i,
  output rv_front_pkg::addr_t      pc_o,
  output logic                    valid_o,
  output rv_front_pkg::fetch_req_t fetch_o
);

  localparam int REQ_W = $bits(rv_front_pkg::fetch_req_t);

  rv_front_pkg::addr_t      pc_q;
  rv_front_pkg::addr_t      pc_next;
  logic                     advance;
  logic                     redir_pending;
  rv_front_pkg::fetch_req_t req;

  // Next-PC mux
  always_comb begin
    case (pc_sel_i)
      rv_front_pkg::PC_SEL_REDIRECT:   pc_next = redir_tgt_i;
      rv_front_pkg::PC_SEL_PREDICTED:  pc_next = pred_tgt_i;
      rv_front_pkg::PC_SEL_SEQUENTIAL: pc_next = pc_q + 32'd4;
      default:                         pc_next = pc_q + 32'd4;
    endcase
  end

  // PC register, held while stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (advance) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // Hazard unit needs an extended flush when the wrong-path fetch already left
  // Redirects always, late predictions too, but not BTB early predictions
  assign redir_pending = (pc_sel_i == rv_front_pkg::PC_SEL_REDIRECT) ||
                         ((pc_sel_i == rv_front_pkg::PC_SEL_PREDICTED) && !btb_early_i);

  // Bundle for IF
  always_comb begin
    req               = '0;
    req.pc            = pc_q;
    req.pc_next       = pc_next;
    req.btb           = btb_i;
    req.ras           = ras_i;
    req.redir_pending = redir_pending;
  end

  // Valid and advance for the PC to IF boundary
  rv_pipe_ctrl #(
    .REG(PC_REG)
  ) pipe_ctrl_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall_i  (stall_i),
    .valid_o  (valid_o),
    .advance_o(advance)
  );

  // One register for the whole request keeps PC and metadata aligned
  rv_pipe_data #(
    .WIDTH(REQ_W),
    .REG  (PC_REG)
  ) pipe_req_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(advance),
    .data_i   (req),
    .data_o   (fetch_o)
  );

endmodule

//--- verilog/rv_front.sv
`timescale 1ns/1ps

module rv_front #(
  parameter int                  PC_REG      = 1,
  parameter rv_front_pkg::addr_t RESET_PC    = 32'h0000_1000,
  parameter int                  BTB_ENTRIES = 8,
  parameter int                  RAS_DEPTH   = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall_i,
  input  rv_front_pkg::redirect_t  redirect_i,
  input  rv_front_pkg::redirect_t  late_pred_i,
  input  rv_front_pkg::bp_update_t bp_update_i,
  output logic                    valid_o,
  output rv_front_pkg::fetch_req_t fetch_o
);

  rv_front_pkg::addr_t     pc;
  rv_front_pkg::btb_meta_t btb_meta;
  rv_front_pkg::ras_meta_t ras_top;
  rv_front_pkg::pc_sel_e   pc_sel;
  rv_front_pkg::addr_t     redir_tgt;
  rv_front_pkg::addr_t     pred_tgt;
  logic                    btb_early;
  logic                    ras_pop;
  logic                    ras_push;
  rv_front_pkg::addr_t     ras_push_addr;

  // Calls push their return address when execute trains the predictor
  assign ras_push      = bp_update_i.valid && bp_update_i.is_call;
  assign ras_push_addr = bp_update_i.pc + 32'd4;

  // Lookup with the live PC, return entries read the RAS top
  rv_btb #(
    .ENTRIES(BTB_ENTRIES)
  ) btb_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .pc_i    (pc),
    .update_i(bp_update_i),
    .ras_i   (ras_top),
    .meta_o  (btb_meta)
  );

  rv_ras #(
    .DEPTH(RAS_DEPTH)
  ) ras_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (ras_push),
    .pop_i      (ras_pop),
    .push_addr_i(ras_push_addr),
    .top_o      (ras_top)
  );

  rv_pc_sel pc_sel_i (
    .stall_i    (stall_i),
    .redirect_i (redirect_i),
    .late_pred_i(late_pred_i),
    .btb_i      (btb_meta),
    .pc_sel_o   (pc_sel),
    .redir_tgt_o(redir_tgt),
    .pred_tgt_o (pred_tgt),
    .btb_early_o(btb_early),
    .ras_pop_o  (ras_pop)
  );

  rv_stage_pc #(
    .PC_REG  (PC_REG),
    .RESET_PC(RESET_PC)
  ) stage_pc_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall_i    (stall_i),
    .pc_sel_i   (pc_sel),
    .redir_tgt_i(redir_tgt),
    .pred_tgt_i (pred_tgt),
    .btb_early_i(btb_early),
    .btb_i      (btb_meta),
    .ras_i      (ras_top),
    .pc_o       (pc),
    .valid_o    (valid_o),
    .fetch_o    (fetch_o)
  );

endmodule

//--- bench/rv_front_tb.sv
`timescale 1ns/1ps

module rv_front_tb;

  localparam int                         PERIOD   = 40;
  localparam rv_front_pkg::addr_t        RESET_PC = 32'h0000_1000;
  localparam rv_front_pkg::redirect_t    NONE     = '0;
  localparam rv_front_pkg::bp_update_t   NO_UPD   = '0;

  // Inputs for one cycle
  typedef struct packed {
    logic                     stall;
    rv_front_pkg::redirect_t  redirect;
    rv_front_pkg::redirect_t  late;
    rv_front_pkg::bp_update_t upd;
  } step_t;

  logic                     clk;
  logic                     rst_n;
  logic                     stall_i;
  rv_front_pkg::redirect_t  redirect_i;
  rv_front_pkg::redirect_t  late_pred_i;
  rv_front_pkg::bp_update_t bp_update_i;
  logic                     valid_o;
  rv_front_pkg::fetch_req_t fetch_o;

  step_t                    table_q[$];
  logic [31:0]              rng;
  // Reference model, 8 BTB entries and a 4 deep RAS
  rv_front_pkg::addr_t      m_pc;
  logic [7:0]               m_bv;
  logic [26:0]              m_btag [8];
  rv_front_pkg::addr_t      m_btgt [8];
  logic                     m_bret [8];
  rv_front_pkg::addr_t      m_stack [4];
  logic [1:0]               m_top;
  logic [2:0]               m_cnt;
  logic                     exp_valid;
  rv_front_pkg::fetch_req_t exp_fetch;

  rv_front #(
    .PC_REG(1)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall_i    (stall_i),
    .redirect_i (redirect_i),
    .late_pred_i(late_pred_i),
    .bp_update_i(bp_update_i),
    .valid_o    (valid_o),
    .fetch_o    (fetch_o)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Run length bound, every row may get one extra stall cycle
  initial begin
    #1;
    repeat (2 * table_q.size() + 24) @(posedge clk);
    $display("Timeout: the step table did not finish in time");
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic rv_front_pkg::redirect_t target(input rv_front_pkg::addr_t tgt);
    return {1'b1, tgt};
  endfunction

  function automatic rv_front_pkg::bp_update_t train(input rv_front_pkg::addr_t pc,
      input rv_front_pkg::addr_t tgt, input logic is_ret, input logic is_call);
    return {1'b1, pc, tgt, is_ret, is_call};
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic check_addr(input string name, input rv_front_pkg::addr_t exp,
      input rv_front_pkg::addr_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_fetch(input string name, input rv_front_pkg::fetch_req_t exp,
      input rv_front_pkg::fetch_req_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("TEST RESULT: FAIL");
      $fatal(1, "fetch request mismatch");
    end
  endtask

  task automatic fill_table();
    // Sequential fetch, then a branch at 0x1010 trained from execute
    table_q.push_back({1'b0, NONE, NONE, NO_UPD});
    table_q.push_back({1'b0, NONE, NONE, NO_UPD});
    table_q.push_back({1'b0, NONE, NONE, train(32'h1010, 32'h1100, 1'b0, 1'b0)});
    table_q.push_back({1'b1, NONE, NONE, NO_UPD});
    table_q.push_back({1'b0, NONE, NONE, NO_UPD});
    // Early hit at 0x1010
    table_q.push_back({1'b0, NONE, NONE, NO_UPD});
    table_q.push_back({1'b0, target(32'h2000), NONE, NO_UPD});
    table_q.push_back({1'b0, NONE, target(32'h3000), NO_UPD});
    // Redirect beats the late prediction
    table_q.push_back({1'b0, target(32'h1000), target(32'h5000), NO_UPD});
    // 0x1030 shares index 4 with 0x1010
    table_q.push_back({1'b0, NONE, NONE, train(32'h1030, 32'h1200, 1'b0, 1'b0)});
    table_q.push_back({1'b0, target(32'h1010), NONE, NO_UPD});
    table_q.push_back({1'b0, NONE, NONE, NO_UPD});
    table_q.push_back({1'b0, target(32'h1030), NONE, NO_UPD});
    table_q.push_back({1'b0, NONE, NONE, NO_UPD});
    // Call at 0x1040 pushes 0x1044, return entry at 0x1504
    table_q.push_back({1'b0, NONE, NONE, train(32'h1040, 32'h1500, 1'b0, 1'b1)});
    table_q.push_back({1'b0, NONE, NONE, train(32'h1504, 32'h0, 1'b1, 1'b0)});
    table_q.push_back({1'b0, target(32'h1500), NONE, NO_UPD});
    table_q.push_back({1'b0, NONE, NONE, NO_UPD});
    // Return seen while stalled, pop only once it advances
    table_q.push_back({1'b1, NONE, NONE, NO_UPD});
    table_q.push_back({1'b0, NONE, NONE, NO_UPD});
    // Back to the return with an empty RAS
    table_q.push_back({1'b0, target(32'h1504), NONE, NO_UPD});
    table_q.push_back({1'b0, NONE, NONE, NO_UPD});
    table_q.push_back({1'b0, NONE, NONE, NO_UPD});
  endtask

  // Expected outputs one edge later, then model state after the edge
  task automatic model_cycle();
    rv_front_pkg::btb_meta_t btb;
    rv_front_pkg::ras_meta_t ras;
    rv_front_pkg::addr_t     nxt;
    logic                    pend;
    logic                    pop;
    logic                    push;
    logic [2:0]              idx;
    idx  = m_pc[4:2];
    btb  = '0;
    ras  = '0;
    pend = 1'b1;
    pop  = 1'b0;
    if (m_cnt != 3'd0) begin
      ras.valid = 1'b1;
      ras.tgt   = m_stack[m_top];
    end
    if (m_bv[idx] && (m_btag[idx] == m_pc[31:5])) begin
      btb.hit        = 1'b1;
      btb.is_return  = m_bret[idx];
      btb.pred_taken = m_bret[idx] ? ras.valid : 1'b1;
      btb.tgt        = m_bret[idx] ? ras.tgt : m_btgt[idx];
    end
    if (redirect_i.valid) begin
      nxt = redirect_i.tgt;
    end else if (late_pred_i.valid) begin
      nxt = late_pred_i.tgt;
    end else if (btb.pred_taken) begin
      nxt  = btb.tgt;
      pend = 1'b0;
      pop  = btb.is_return && !stall_i;
    end else begin
      nxt  = m_pc + 32'd4;
      pend = 1'b0;
    end
    exp_valid = !stall_i;
    if (!stall_i) begin
      exp_fetch = {m_pc, nxt, btb, ras, pend};
      m_pc      = nxt;
    end
    // Training writes the whole entry
    if (bp_update_i.valid) begin
      idx         = bp_update_i.pc[4:2];
      m_bv[idx]   = 1'b1;
      m_btag[idx] = bp_update_i.pc[31:5];
      m_btgt[idx] = bp_update_i.tgt;
      m_bret[idx] = bp_update_i.is_return;
    end
    push = bp_update_i.valid && bp_update_i.is_call;
    if (push && pop) begin
      m_stack[m_top] = bp_update_i.pc + 32'd4;
    end else if (push) begin
      m_top          = m_top + 2'd1;
      m_stack[m_top] = bp_update_i.pc + 32'd4;
      if (m_cnt != 3'd4) begin
        m_cnt = m_cnt + 3'd1;
      end
    end else if (pop) begin
      m_top = m_top - 2'd1;
      m_cnt = m_cnt - 3'd1;
    end
  endtask

  task automatic step_and_check();
    @(posedge clk);
    #1;
    check_bit("valid_o", exp_valid, valid_o);
    check_addr("fetch_o.pc", exp_fetch.pc, fetch_o.pc);
    check_addr("fetch_o.pc_next", exp_fetch.pc_next, fetch_o.pc_next);
    check_fetch("fetch_o", exp_fetch, fetch_o);
    #1;
  endtask

  initial begin
    step_t row;
    rst_n       = 1'b0;
    stall_i     = 1'b0;
    redirect_i  = '0;
    late_pred_i = '0;
    bp_update_i = '0;
    rng         = 32'd46;
    m_pc        = RESET_PC;
    m_bv        = '0;
    m_top       = '0;
    m_cnt       = '0;
    exp_fetch   = '0;
    fill_table();
    repeat (4) @(posedge clk);
    #1;
    check_bit("valid_o", 1'b0, valid_o);
    check_fetch("fetch_o", '0, fetch_o);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < table_q.size(); i++) begin
      // Random extra stall, redirect and late prediction held
      rng = xorshift(rng);
      if (rng[1:0] == 2'b00) begin
        stall_i     = 1'b1;
        bp_update_i = '0;
        model_cycle();
        step_and_check();
      end
      row     = table_q[i];
      stall_i = row.stall;
      if (!row.stall) begin
        redirect_i  = row.redirect;
        late_pred_i = row.late;
      end
      bp_update_i = row.upd;
      model_cycle();
      step_and_check();
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- rv_front.f
verilog/rv_front_pkg.sv
verilog/rv_pipe_ctrl.sv
verilog/rv_pipe_data.sv
verilog/rv_btb.sv
verilog/rv_ras.sv
verilog/rv_pc_sel.sv
verilog/rv_stage_pc.sv
verilog/rv_front.sv
bench/rv_front_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --timescale 1ns/1ps --top-module rv_front_tb \
  -f rv_front.f -o rv_front_sim \
  && ./obj_dir/rv_front_sim \
  || { echo "rv_front simulation failed"; exit 1; }
